// File: logic/bpu_btb.sv
`timescale 1ns/1ps

module bpu_btb import bpu_pkg::*; #(
    parameter int BTB_IDX_LEN = 6
) (
    input  logic                clk,
    input  logic                rst_n,
    // lookup, one entry per slot of the group
    input  addr_t               rd_pc_i,
    // single write port from the correction arbiter
    input  logic                we_i,
    input  addr_t               w_pc_i,
    input  logic                w_bank_i,
    input  addr_t               w_target_i,
    input  br_type_t            w_br_type_i,
    output logic     [1:0]      hit_o,
    output br_type_t [1:0]      br_type_o,
    output addr_t    [1:0]      target_o
);

    localparam int DEPTH = 1 << BTB_IDX_LEN;

    logic [BTB_IDX_LEN-1:0] rd_idx;
    logic [BTB_IDX_LEN-1:0] w_idx;
    btb_tag_t               rd_tag;
    btb_tag_t               w_tag;

    // valid bits, cleared by reset
    logic [1:0][DEPTH-1:0]  valid_q;

    // payload arrays, plain ram
    btb_tag_t               tag_q    [2][DEPTH];
    addr_t                  target_q [2][DEPTH];
    br_type_t               type_q   [2][DEPTH];

    assign rd_idx = BTB_IDX_LEN'(idx_fold(rd_pc_i));
    assign w_idx  = BTB_IDX_LEN'(idx_fold(w_pc_i));
    assign rd_tag = rd_pc_i[12 +: TAG_LEN];   // pc[19:12]
    assign w_tag  = w_pc_i[12 +: TAG_LEN];

    // both banks read at the same index, bank = slot
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            hit_o[b]     = valid_q[b][rd_idx] && (tag_q[b][rd_idx] == rd_tag);
            br_type_o[b] = type_q[b][rd_idx];
            target_o[b]  = target_q[b][rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;                         // empty btb
        end else if (we_i) begin
            valid_q[w_bank_i][w_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[w_bank_i][w_idx]    <= w_tag;
            target_q[w_bank_i][w_idx] <= w_target_i;
            type_q[w_bank_i][w_idx]   <= w_br_type_i;
        end
    end

endmodule

// File: logic/bpu_correct_arb.sv
`timescale 1ns/1ps

module bpu_correct_arb import bpu_pkg::*; (
    // correction slot 0, wins whenever it updates
    input  logic     c0_update_i,
    input  addr_t    c0_pc_i,
    input  addr_t    c0_target_i,
    input  br_type_t c0_br_type_i,
    input  logic     c0_is_branch_i,
    input  logic     c0_taken_i,
    input  logic     c0_type_miss_i,
    input  hist_t    c0_history_i,
    input  scnt_t    c0_scnt_i,
    // correction slot 1
    input  logic     c1_update_i,
    input  addr_t    c1_pc_i,
    input  addr_t    c1_target_i,
    input  br_type_t c1_br_type_i,
    input  logic     c1_is_branch_i,
    input  logic     c1_taken_i,
    input  logic     c1_type_miss_i,
    input  hist_t    c1_history_i,
    input  scnt_t    c1_scnt_i,
    // shared write port into the tables
    output addr_t    w_pc_o,
    output addr_t    w_target_o,
    output br_type_t w_br_type_o,
    output logic     w_taken_o,
    output logic     w_type_miss_o,
    output hist_t    w_hist_o,
    output scnt_t    w_scnt_o,
    output addr_t    w_push_addr_o,  // return address for a call
    output logic     btb_we_o,
    output logic     dir_we_o,
    output logic     ras_push_o,
    output logic     ras_pop_o,
    output logic     w_slot_o        // bank select, pc[2]
);

    logic any_update;
    logic sel_is_branch;

    assign any_update = c0_update_i | c1_update_i;

    // fixed priority mux, slot 1 only when slot 0 is idle
    always_comb begin
        if (c0_update_i) begin
            w_pc_o        = c0_pc_i;
            w_target_o    = c0_target_i;
            w_br_type_o   = c0_br_type_i;
            sel_is_branch = c0_is_branch_i;
            w_taken_o     = c0_taken_i;
            w_type_miss_o = c0_type_miss_i;
            w_hist_o      = c0_history_i;
            w_scnt_o      = c0_scnt_i;
        end else begin
            w_pc_o        = c1_pc_i;
            w_target_o    = c1_target_i;
            w_br_type_o   = c1_br_type_i;
            sel_is_branch = c1_is_branch_i;
            w_taken_o     = c1_taken_i;
            w_type_miss_o = c1_type_miss_i;
            w_hist_o      = c1_history_i;
            w_scnt_o      = c1_scnt_i;
        end
    end

    assign w_slot_o      = w_pc_o[2];         // odd word goes to bank 1
    assign w_push_addr_o = w_pc_o + 32'd4;    // instruction after the call

    // btb refresh on a type miss, or on any taken branch so a moved
    // target gets rewritten
    assign btb_we_o   = any_update & (w_type_miss_o | (sel_is_branch & w_taken_o));
    assign dir_we_o   = any_update;           // history and counters on every report
    assign ras_push_o = any_update & (w_br_type_o == BR_CALL);
    assign ras_pop_o  = any_update & (w_br_type_o == BR_RET);

endmodule

// File: logic/bpu_dir_pred.sv
`timescale 1ns/1ps

module bpu_dir_pred import bpu_pkg::*; #(
    parameter int BTB_IDX_LEN = 6,
    parameter int PHT_PC_LEN  = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  addr_t            rd_pc_i,
    // write side, trained only by corrections
    input  logic             we_i,
    input  addr_t            w_pc_i,
    input  logic             w_bank_i,
    input  logic             w_taken_i,
    input  logic             w_type_miss_i,
    input  hist_t            w_hist_i,      // history the backend predicted with
    input  scnt_t            w_scnt_i,      // counter value it saw
    output logic  [1:0]      taken_o,
    output hist_t [1:0]      hist_o,
    output scnt_t [1:0]      scnt_o
);

    localparam int BHT_DEPTH   = 1 << BTB_IDX_LEN;
    localparam int PHT_IDX_LEN = HIST_LEN + PHT_PC_LEN;
    localparam int PHT_DEPTH   = 1 << PHT_IDX_LEN;

    // local history per bank, same index as the btb
    hist_t [1:0][BHT_DEPTH-1:0] bht_q;
    // pattern table per bank, {history, pc[5:3]}
    scnt_t [1:0][PHT_DEPTH-1:0] pht_q;

    logic [BTB_IDX_LEN-1:0]       rd_idx;
    logic [BTB_IDX_LEN-1:0]       w_idx;
    logic [1:0][PHT_IDX_LEN-1:0]  rd_pht_idx;
    logic [PHT_IDX_LEN-1:0]       w_pht_idx;
    hist_t                        hist_next;
    scnt_t                        scnt_next;

    assign rd_idx = BTB_IDX_LEN'(idx_fold(rd_pc_i));
    assign w_idx  = BTB_IDX_LEN'(idx_fold(w_pc_i));

    // two level read, history first then counter
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            hist_o[b]     = bht_q[b][rd_idx];
            rd_pht_idx[b] = {hist_o[b], rd_pc_i[3 +: PHT_PC_LEN]};
            scnt_o[b]     = pht_q[b][rd_pht_idx[b]];
            taken_o[b]    = scnt_o[b][1];           // msb says taken
        end
    end

    // new history
    // a type miss means the old bits belong to something else,
    // so refill with the outcome
    always_comb begin
        if (w_type_miss_i) begin
            hist_next = {HIST_LEN{w_taken_i}};
        end else begin
            hist_next = {w_hist_i[HIST_LEN-2:0], w_taken_i};
        end
    end

    // one step toward the outcome, saturating at 0 and 3
    always_comb begin
        scnt_next = w_scnt_i;
        if (w_taken_i && (w_scnt_i != 2'd3)) begin
            scnt_next = w_scnt_i + 2'd1;
        end else if (!w_taken_i && (w_scnt_i != 2'd0)) begin
            scnt_next = w_scnt_i - 2'd1;
        end
    end

    // counter addressed with the reported history, not the current one
    assign w_pht_idx = {w_hist_i, w_pc_i[3 +: PHT_PC_LEN]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bht_q <= '0;
            pht_q <= '0;    // strongly not taken everywhere
        end else if (we_i) begin
            bht_q[w_bank_i][w_idx]     <= hist_next;
            pht_q[w_bank_i][w_pht_idx] <= scnt_next;
        end
    end

endmodule

// File: logic/bpu_pc_gen.sv
`timescale 1ns/1ps

module bpu_pc_gen import bpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,        // redirect from backend
    input  addr_t              redir_addr_i,
    input  logic               ready_i,        // fetch takes the group
    // lookups of the current group
    input  logic     [1:0]     hit_i,
    input  br_type_t [1:0]     br_type_i,
    input  addr_t    [1:0]     target_i,
    input  logic     [1:0]     dir_taken_i,
    input  addr_t              ras_top_i,
    output addr_t              pc_o,
    output logic     [1:0]     mask_o,
    output logic     [1:0]     taken_o,
    output addr_t    [1:0]     next_pc_o,
    output addr_t    [1:0]     pred_target_o
);

    addr_t      pc_q;
    addr_t      seq_pc;      // next 8-byte group
    addr_t      pc_next;
    logic [1:0] branch;

    assign pc_o   = pc_q;
    assign seq_pc = {pc_q[31:3] + 29'd1, 3'b000};

    // per slot decision
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            // unconditional classes always go, conditional asks the counter
            branch[s] = hit_i[s] & ((br_type_i[s] != BR_NORMAL) | dir_taken_i[s]);
            pred_target_o[s] = (br_type_i[s] == BR_RET) ? ras_top_i : target_i[s];
        end
    end

    assign taken_o[0] = branch[0] & ~pc_q[2];    // entry in slot 1, slot 0 dead
    assign taken_o[1] = branch[1];

    // fall-through of slot 0 is the other word of this group
    assign next_pc_o[0] = taken_o[0] ? pred_target_o[0] : {pc_q[31:3], 3'b100};
    assign next_pc_o[1] = taken_o[1] ? pred_target_o[1] : seq_pc;

    // slot 1 dies behind a taken slot 0
    assign mask_o = {~taken_o[0], ~pc_q[2]};

    // first taken slot wins
    always_comb begin
        if (taken_o[0]) begin
            pc_next = pred_target_o[0];
        end else if (taken_o[1]) begin
            pc_next = pred_target_o[1];
        end else begin
            pc_next = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc_q <= redir_addr_i;      // flush beats back-pressure
        end else if (ready_i) begin
            pc_q <= pc_next;
        end
    end

endmodule

// File: logic/bpu_pkg.sv
package bpu_pkg;

    // widths shared by every table
    localparam int HIST_LEN = 5;    // local history bits per entry
    localparam int TAG_LEN  = 8;    // btb tag, pc[19:12]

    typedef logic [31:0]         addr_t;     // instruction address
    typedef logic [1:0]          br_type_t;  // branch class
    typedef logic [1:0]          scnt_t;     // 2-bit saturating counter, msb = taken
    typedef logic [HIST_LEN-1:0] hist_t;     // local history, newest bit at lsb
    typedef logic [TAG_LEN-1:0]  btb_tag_t;  // btb tag

    // branch class codes
    localparam br_type_t BR_NORMAL = 2'd0;  // conditional
    localparam br_type_t BR_JUMP   = 2'd1;  // direct unconditional
    localparam br_type_t BR_CALL   = 2'd2;  // bl, pushes the return address
    localparam br_type_t BR_RET    = 2'd3;  // jirl return, target from ras

    // first fetch group after reset
    localparam addr_t BPU_INIT_PC = 32'h1c00_0000;

    // table index fold
    // bits [k-1:0] of the result are pc[12 +: k] ^ pc[3 +: k],
    // callers cut it down to their own index width
    function automatic addr_t idx_fold(input addr_t pc);
        return (pc >> 12) ^ (pc >> 3);
    endfunction

endpackage

// File: logic/bpu_ras.sv
`timescale 1ns/1ps

module bpu_ras import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push_i,       // call reported
    input  logic  pop_i,        // return reported
    input  addr_t push_addr_i,  // call pc + 4
    output addr_t top_o
);

    localparam int PTR_LEN = $clog2(RAS_DEPTH);

    addr_t               stack_q [RAS_DEPTH];  // circular, no reset
    logic  [PTR_LEN-1:0] top_q;                // points at the newest entry
    logic  [PTR_LEN-1:0] push_ptr;

    assign push_ptr = top_q + 1'b1;   // slot above the top, wraps
    assign top_o    = stack_q[top_q];

    // pointer
    // reset parks it one below slot 0 so the first push lands there
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= '1;
        end else if (push_i) begin
            top_q <= push_ptr;
        end else if (pop_i) begin
            top_q <= top_q - 1'b1;     // underflow just wraps
        end
    end

    // overflow overwrites the oldest entry through the wrap
    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[push_ptr] <= push_addr_i;
        end
    end

endmodule

// File: logic/bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; #(
    parameter int BTB_IDX_LEN = 6,   // btb and bht index
    parameter int PHT_PC_LEN  = 3,   // pc bits under the history in the pht index
    parameter int RAS_DEPTH   = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,
    input  addr_t              redir_addr_i,
    input  logic               ready_i,
    // backend correction, slot 0
    input  logic               c0_update_i,
    input  addr_t              c0_pc_i,
    input  addr_t              c0_target_i,
    input  br_type_t           c0_br_type_i,
    input  logic               c0_is_branch_i,
    input  logic               c0_taken_i,
    input  logic               c0_type_miss_i,
    input  hist_t              c0_history_i,
    input  scnt_t              c0_scnt_i,
    // backend correction, slot 1
    input  logic               c1_update_i,
    input  addr_t              c1_pc_i,
    input  addr_t              c1_target_i,
    input  br_type_t           c1_br_type_i,
    input  logic               c1_is_branch_i,
    input  logic               c1_taken_i,
    input  logic               c1_type_miss_i,
    input  hist_t              c1_history_i,
    input  scnt_t              c1_scnt_i,
    // prediction for the current group
    output addr_t              pc_o,
    output logic     [1:0]     mask_o,
    output logic     [1:0]     taken_o,
    output addr_t    [1:0]     next_pc_o,
    output addr_t    [1:0]     pred_target_o,
    output hist_t    [1:0]     hist_o,   // handed back with corrections
    output scnt_t    [1:0]     scnt_o
);

    // shared write bus
    addr_t    w_pc;
    addr_t    w_target;
    br_type_t w_br_type;
    logic     w_taken;
    logic     w_type_miss;
    hist_t    w_hist;
    scnt_t    w_scnt;
    addr_t    w_push_addr;
    logic     w_slot;
    logic     btb_we;
    logic     dir_we;
    logic     ras_push;
    logic     ras_pop;

    // lookup results into the pc generator
    logic     [1:0] btb_hit;
    br_type_t [1:0] btb_type;
    addr_t    [1:0] btb_target;
    logic     [1:0] dir_taken;
    addr_t          ras_top;

    bpu_correct_arb u_arb (
        .c0_update_i    (c0_update_i),
        .c0_pc_i        (c0_pc_i),
        .c0_target_i    (c0_target_i),
        .c0_br_type_i   (c0_br_type_i),
        .c0_is_branch_i (c0_is_branch_i),
        .c0_taken_i     (c0_taken_i),
        .c0_type_miss_i (c0_type_miss_i),
        .c0_history_i   (c0_history_i),
        .c0_scnt_i      (c0_scnt_i),
        .c1_update_i    (c1_update_i),
        .c1_pc_i        (c1_pc_i),
        .c1_target_i    (c1_target_i),
        .c1_br_type_i   (c1_br_type_i),
        .c1_is_branch_i (c1_is_branch_i),
        .c1_taken_i     (c1_taken_i),
        .c1_type_miss_i (c1_type_miss_i),
        .c1_history_i   (c1_history_i),
        .c1_scnt_i      (c1_scnt_i),
        .w_pc_o         (w_pc),
        .w_target_o     (w_target),
        .w_br_type_o    (w_br_type),
        .w_taken_o      (w_taken),
        .w_type_miss_o  (w_type_miss),
        .w_hist_o       (w_hist),
        .w_scnt_o       (w_scnt),
        .w_push_addr_o  (w_push_addr),
        .btb_we_o       (btb_we),
        .dir_we_o       (dir_we),
        .ras_push_o     (ras_push),
        .ras_pop_o      (ras_pop),
        .w_slot_o       (w_slot)
    );

    bpu_btb #(
        .BTB_IDX_LEN (BTB_IDX_LEN)
    ) u_btb (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_pc_i     (pc_o),
        .we_i        (btb_we),
        .w_pc_i      (w_pc),
        .w_bank_i    (w_slot),
        .w_target_i  (w_target),
        .w_br_type_i (w_br_type),
        .hit_o       (btb_hit),
        .br_type_o   (btb_type),
        .target_o    (btb_target)
    );

    bpu_dir_pred #(
        .BTB_IDX_LEN (BTB_IDX_LEN),
        .PHT_PC_LEN  (PHT_PC_LEN)
    ) u_dir (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_pc_i       (pc_o),
        .we_i          (dir_we),
        .w_pc_i        (w_pc),
        .w_bank_i      (w_slot),
        .w_taken_i     (w_taken),
        .w_type_miss_i (w_type_miss),
        .w_hist_i      (w_hist),
        .w_scnt_i      (w_scnt),
        .taken_o       (dir_taken),
        .hist_o        (hist_o),
        .scnt_o        (scnt_o)
    );

    bpu_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (w_push_addr),
        .top_o       (ras_top)
    );

    bpu_pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .redir_addr_i  (redir_addr_i),
        .ready_i       (ready_i),
        .hit_i         (btb_hit),
        .br_type_i     (btb_type),
        .target_i      (btb_target),
        .dir_taken_i   (dir_taken),
        .ras_top_i     (ras_top),
        .pc_o          (pc_o),
        .mask_o        (mask_o),
        .taken_o       (taken_o),
        .next_pc_o     (next_pc_o),
        .pred_target_o (pred_target_o)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the bpu testbench with verilator and runs it from the project root
# the exit status is the simulator's, a $fatal gives a nonzero status
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module bpu_tb \
    -f tb.f \
    -o bpu_tb_sim

./obj_dir/bpu_tb_sim

// File: sim/bpu_patterns.txt
// ctl redir c0_info c0_pc c0_tgt c1_info c1_pc c1_tgt | exp_pc mask_taken exp_next0 exp_next1
// ctl nibbles: test, flush, ready (2 = seeded random), f00 ends the list
// info nibbles: update, br_type, is_branch, taken, type_miss, history (2), scnt
// test 1: reset state, steps of 8 with ready high, hold with ready low
101 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c000000 30 1c000004 1c000008
101 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c000008 30 1c00000c 1c000010
100 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c000010 30 1c000014 1c000018
100 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c000010 30 1c000014 1c000018
101 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c000010 30 1c000014 1c000018
// test 2: flush while ready is low, start on the odd word
210 1c001004 00000000 00000000 00000000 00000000 00000000 00000000 1c000018 30 1c00001c 1c000020
201 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c001004 20 1c001004 1c001008
// test 3: jump trained and flushed to in the same cycle
310 1c002010 11111000 1c002010 1c003000 00000000 00000000 00000000 1c001008 30 1c00100c 1c001010
301 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c002010 11 1c003000 1c002018
300 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c003000 30 1c003004 1c003008
// test 4: conditional branch in slot 1, counter walk with pc held
412 1c004020 00000000 00000000 00000000 00000000 00000000 00000000 1c003000 30 1c003004 1c003008
400 00000000 10111000 1c004024 1c004100 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
400 00000000 101101f0 1c004024 1c004100 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
400 00000000 101101f1 1c004024 1c004100 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
400 00000000 101001f2 1c004024 1c004100 00000000 00000000 00000000 1c004020 32 1c004024 1c004100
400 00000000 101001e0 1c004024 1c004100 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
400 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
// test 5: return entry, then calls, nested call through slot 1
500 00000000 13111000 1c006004 00000000 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
500 00000000 12111000 1c005000 1c008000 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
510 1c006000 00000000 00000000 00000000 00000000 00000000 00000000 1c004020 30 1c004024 1c004028
500 00000000 00000000 00000000 00000000 12111000 1c007010 1c008800 1c006000 32 1c006004 1c005004
500 00000000 13110000 1c006004 00000000 00000000 00000000 00000000 1c006000 32 1c006004 1c007014
500 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c006000 32 1c006004 1c005004
// test 6: both slots report, only slot 0 lands in the tables
600 00000000 11111000 1c009000 1c00a000 11111000 1c00b000 1c00c000 1c006000 32 1c006004 1c005004
610 1c00b000 00000000 00000000 00000000 00000000 00000000 00000000 1c006000 32 1c006004 1c005004
601 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c00b000 30 1c00b004 1c00b008
612 1c009000 00000000 00000000 00000000 00000000 00000000 00000000 1c00b008 30 1c00b00c 1c00b010
601 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c009000 11 1c00a000 1c009008
600 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1c00a000 30 1c00a004 1c00a008
f00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00 00000000 00000000

// File: sim/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_WORDS    = 12;     // hex words per pattern line
    localparam int MAX_STEPS  = 64;

    // word offsets inside one line
    localparam int W_CTL     = 0;
    localparam int W_REDIR   = 1;
    localparam int W_C0_INFO = 2;
    localparam int W_C0_PC   = 3;
    localparam int W_C0_TGT  = 4;
    localparam int W_C1_INFO = 5;
    localparam int W_C1_PC   = 6;
    localparam int W_C1_TGT  = 7;
    localparam int W_PC      = 8;
    localparam int W_MT      = 9;       // mask in [5:4], taken in [1:0]
    localparam int W_N0      = 10;
    localparam int W_N1      = 11;

    logic           clk;
    logic           rst_n;
    logic           flush;
    addr_t          redir_addr;
    logic           ready;
    logic           c0_update;
    logic           c1_update;
    addr_t          c0_pc;
    addr_t          c1_pc;
    addr_t          c0_target;
    addr_t          c1_target;
    br_type_t       c0_br_type;
    br_type_t       c1_br_type;
    logic           c0_is_branch;
    logic           c1_is_branch;
    logic           c0_taken;
    logic           c1_taken;
    logic           c0_type_miss;
    logic           c1_type_miss;
    hist_t          c0_history;
    hist_t          c1_history;
    scnt_t          c0_scnt;
    scnt_t          c1_scnt;
    addr_t          pc;
    logic     [1:0] mask;
    logic     [1:0] taken;
    addr_t    [1:0] next_pc;
    addr_t    [1:0] pred_target;
    hist_t    [1:0] hist;
    scnt_t    [1:0] scnt;

    logic [31:0] pat_mem [MAX_STEPS*N_WORDS];
    int          n_steps;
    int          cycle_count = 0;
    int          cycle_limit = MAX_STEPS * 4;  // tightened once the file is read

    bpu_top #(
        .BTB_IDX_LEN (6),
        .PHT_PC_LEN  (3),
        .RAS_DEPTH   (8)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush),
        .redir_addr_i   (redir_addr),
        .ready_i        (ready),
        .c0_update_i    (c0_update),
        .c0_pc_i        (c0_pc),
        .c0_target_i    (c0_target),
        .c0_br_type_i   (c0_br_type),
        .c0_is_branch_i (c0_is_branch),
        .c0_taken_i     (c0_taken),
        .c0_type_miss_i (c0_type_miss),
        .c0_history_i   (c0_history),
        .c0_scnt_i      (c0_scnt),
        .c1_update_i    (c1_update),
        .c1_pc_i        (c1_pc),
        .c1_target_i    (c1_target),
        .c1_br_type_i   (c1_br_type),
        .c1_is_branch_i (c1_is_branch),
        .c1_taken_i     (c1_taken),
        .c1_type_miss_i (c1_type_miss),
        .c1_history_i   (c1_history),
        .c1_scnt_i      (c1_scnt),
        .pc_o           (pc),
        .mask_o         (mask),
        .taken_o        (taken),
        .next_pc_o      (next_pc),
        .pred_target_o  (pred_target),
        .hist_o         (hist),
        .scnt_o         (scnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // run limit, counts from time 0 including reset
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: pattern run still busy after %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // steps before the f00 marker, -1 when there is none
    function automatic int count_steps();
        for (int i = 0; i < MAX_STEPS; i++) begin
            if (pat_mem[i*N_WORDS + W_CTL][11:8] == 4'hf) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic apply_step(input int s);
        int          base;
        logic [31:0] ctl;
        logic [31:0] info0;
        logic [31:0] info1;
        logic [31:0] rnd;
        base  = s * N_WORDS;
        ctl   = pat_mem[base + W_CTL];
        info0 = pat_mem[base + W_C0_INFO];
        info1 = pat_mem[base + W_C1_INFO];
        rnd   = $urandom();
        flush      = ctl[4];
        redir_addr = pat_mem[base + W_REDIR];
        ready      = (ctl[1:0] == 2'd2) ? rnd[0] : ctl[0];   // mode 2 only on flush lines
        c0_update    = info0[28];
        c0_br_type   = info0[25:24];
        c0_is_branch = info0[20];
        c0_taken     = info0[16];
        c0_type_miss = info0[12];
        c0_history   = info0[8:4];
        c0_scnt      = info0[1:0];
        c0_pc        = pat_mem[base + W_C0_PC];
        c0_target    = pat_mem[base + W_C0_TGT];
        c1_update    = info1[28];
        c1_br_type   = info1[25:24];
        c1_is_branch = info1[20];
        c1_taken     = info1[16];
        c1_type_miss = info1[12];
        c1_history   = info1[8:4];
        c1_scnt      = info1[1:0];
        c1_pc        = pat_mem[base + W_C1_PC];
        c1_target    = pat_mem[base + W_C1_TGT];
    endtask

    task automatic check_field(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s %s: expected %h, actual %h", name, field, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    // a conditional report on the group in view carries the history and
    // counter that its slot shows before the write lands
    task automatic check_report_state(input string name, input logic [31:0] info,
                                      input addr_t rpc, input addr_t exp_pc);
        int slot;
        slot = int'(rpc[2]);
        if (info[28] && (info[25:24] == BR_NORMAL) && (rpc[31:3] == exp_pc[31:3])) begin
            check_field(name, $sformatf("hist[%0d]", slot), {27'd0, info[8:4]},
                        {27'd0, hist[slot]});
            check_field(name, $sformatf("scnt[%0d]", slot), {30'd0, info[1:0]},
                        {30'd0, scnt[slot]});
        end
    endtask

    task automatic check_outputs(input int s);
        int          base;
        string       name;
        logic [31:0] exp_mt;
        base   = s * N_WORDS;
        exp_mt = pat_mem[base + W_MT];
        name   = $sformatf("test %0d step %0d", pat_mem[base + W_CTL][11:8], s);
        check_field(name, "pc", pat_mem[base + W_PC], pc);
        check_field(name, "mask", {30'd0, exp_mt[5:4]}, {30'd0, mask});
        check_field(name, "taken", {30'd0, exp_mt[1:0]}, {30'd0, taken});
        check_field(name, "next_pc[0]", pat_mem[base + W_N0], next_pc[0]);
        check_field(name, "next_pc[1]", pat_mem[base + W_N1], next_pc[1]);
        // a taken slot leaves through its predicted target
        for (int k = 0; k < 2; k++) begin
            if (exp_mt[k]) begin
                check_field(name, $sformatf("pred_target[%0d]", k),
                            pat_mem[base + W_N0 + k], pred_target[k]);
            end
        end
        check_report_state(name, pat_mem[base + W_C0_INFO], pat_mem[base + W_C0_PC],
                           pat_mem[base + W_PC]);
        check_report_state(name, pat_mem[base + W_C1_INFO], pat_mem[base + W_C1_PC],
                           pat_mem[base + W_PC]);
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h7d78));      // single seed for the whole run
        $readmemh("sim/bpu_patterns.txt", pat_mem);
        n_steps = count_steps();
        if (n_steps <= 0) begin
            $display("pattern file is missing, empty or has no end marker");
            $display("RESULT: FAIL");
            $fatal(1, "bad pattern file");
        end
        apply_step(n_steps);            // end marker line, every input idle
        cycle_limit = n_steps * 4;
        repeat (3) @(posedge clk);

        for (int s = 0; s < n_steps; s++) begin
            @(negedge clk);
            rst_n = 1'b1;
            apply_step(s);
            #(CLK_PERIOD/2 - 2);        // just ahead of the rising edge
            check_outputs(s);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb.f
logic/bpu_pkg.sv
logic/bpu_correct_arb.sv
logic/bpu_btb.sv
logic/bpu_dir_pred.sv
logic/bpu_ras.sv
logic/bpu_pc_gen.sv
logic/bpu_top.sv
sim/bpu_tb.sv
